//--- hw/rob_pkg.sv
// rob_pkg: sizes, payload types and cause layout shared by the reorder buffer blocks
`default_nettype none

package rob_pkg;

    localparam int DEC_W     = 2;               // decode slots per cycle
    localparam int REN_W     = 2;               // rename write-back slots
    localparam int EXE_W     = 2;               // execute write-back slots
    localparam int COM_W     = 2;               // commit slots
    localparam int ROB_DEPTH = 16;
    localparam int IDX_W     = $clog2(ROB_DEPTH);
    localparam int CNT_W     = IDX_W + 1;       // occupancy, reaches ROB_DEPTH
    localparam int RET_W     = $clog2(COM_W + 1);
    localparam int XLEN      = 64;
    localparam int LREG_W    = 5;
    localparam int PREG_W    = 7;

    // cause code is {valid, interrupt, code[5:0]}
    localparam int CAUSE_W   = 8;
    localparam int CAUSE_VLD = 7;               // set when the entry traps

    typedef logic [IDX_W-1:0]   rob_idx_t;
    typedef logic [CAUSE_W-1:0] rob_cause_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [LREG_W-1:0] lrd;                 // logical destination
    } rob_dec_t;

    typedef struct packed {
        logic [PREG_W-1:0] prd;                 // physical destination
    } rob_ren_t;

endpackage

`default_nettype wire

//--- hw/rob_mwp_ram.sv
// rob_mwp_ram: register array with several synchronous write ports and combinational reads
`timescale 1ns/100ps
`default_nettype none

module rob_mwp_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16,
    parameter int  RPORTS    = 2,
    parameter int  WPORTS    = 2
) (
    input  logic                           clk,
    input  logic                           rst,
    input  rob_pkg::rob_idx_t [WPORTS-1:0] waddr,
    input  payload_t          [WPORTS-1:0] wvalue,
    input  logic              [WPORTS-1:0] wena,
    input  rob_pkg::rob_idx_t [RPORTS-1:0] raddr,
    output payload_t          [RPORTS-1:0] rvalue
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < WPORTS; i++) begin
            if (wena[i]) begin
                mem[waddr[i]] <= wvalue[i];     // higher port wins
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RPORTS; i++) begin
            rvalue[i] = mem[raddr[i]];
        end
    end

    // producers never aim two live ports at one entry
    for (genvar i = 0; i < WPORTS; i++) begin : g_wr_chk
        for (genvar j = i + 1; j < WPORTS; j++) begin : g_pair
            a_wr_unique: assert property (@(posedge clk) disable iff (rst)
                !(wena[i] && wena[j] && waddr[i] == waddr[j]));
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_status.sv
// rob_status: head pointer, occupancy and per-entry executed and fault bits of the ROB
`timescale 1ns/100ps
`default_nettype none

module rob_status (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [rob_pkg::DEC_W-1:0]                  dec_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::DEC_W-1:0]     dec_opid,
    input  logic [rob_pkg::EXE_W-1:0]                  exe_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::EXE_W-1:0]     exe_opid,
    input  rob_pkg::rob_cause_t [rob_pkg::EXE_W-1:0]   exe_cause,
    input  logic [rob_pkg::RET_W-1:0]                  retire_cnt,
    input  logic                                       trunc_valid,
    input  rob_pkg::rob_idx_t                          trunc_opid,
    output rob_pkg::rob_idx_t                          head,
    output logic [rob_pkg::CNT_W-1:0]                  rob_count,
    output logic [rob_pkg::ROB_DEPTH-1:0]              done,
    output logic [rob_pkg::ROB_DEPTH-1:0]              faulted
);

    logic [rob_pkg::CNT_W-1:0] alloc_cnt;
    logic [rob_pkg::CNT_W-1:0] keep_cnt;
    rob_pkg::rob_idx_t         keep_off;

    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < rob_pkg::DEC_W; i++) begin
            alloc_cnt = alloc_cnt + rob_pkg::CNT_W'(dec_valid[i]);
        end
    end

    // entries kept on a redirect run from head up to trunc_opid;
    // a faulted head means the whole buffer goes
    assign keep_off = trunc_opid - head;
    assign keep_cnt = (done[head] && faulted[head]) ? '0
                    : rob_pkg::CNT_W'(keep_off) + rob_pkg::CNT_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            rob_count <= '0;
            done      <= '0;
            faulted   <= '0;
        end else begin
            head <= head + rob_pkg::IDX_W'(retire_cnt);
            if (trunc_valid) begin
                rob_count <= keep_cnt;          // younger allocations dropped too
            end else begin
                rob_count <= rob_count + alloc_cnt - rob_pkg::CNT_W'(retire_cnt);
            end
            for (int i = 0; i < rob_pkg::DEC_W; i++) begin
                if (dec_valid[i]) begin
                    done[dec_opid[i]]    <= 1'b0;
                    faulted[dec_opid[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < rob_pkg::EXE_W; i++) begin
                if (exe_valid[i]) begin
                    done[exe_opid[i]]    <= 1'b1;
                    faulted[exe_opid[i]] <= exe_cause[i][rob_pkg::CAUSE_VLD];
                end
            end
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        rob_count <= rob_pkg::CNT_W'(rob_pkg::ROB_DEPTH));

endmodule

`default_nettype wire

//--- hw/rob_commit_select.sv
// rob_commit_select: in-order commit of the ready entries at the ROB head
`timescale 1ns/100ps
`default_nettype none

module rob_commit_select (
    input  rob_pkg::rob_idx_t                                head,
    input  logic [rob_pkg::CNT_W-1:0]                        rob_count,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                    done,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                    faulted,
    input  rob_pkg::rob_dec_t [rob_pkg::COM_W-1:0]           dec_rvalue,
    input  rob_pkg::rob_ren_t [rob_pkg::COM_W-1:0]           ren_rvalue,
    input  logic                                             trunc_valid,
    output rob_pkg::rob_idx_t [rob_pkg::COM_W-1:0]           raddr,
    output logic [rob_pkg::COM_W-1:0]                        com_valid,
    output rob_pkg::rob_idx_t [rob_pkg::COM_W-1:0]           com_opid,
    output logic [rob_pkg::COM_W-1:0][rob_pkg::XLEN-1:0]     com_pc,
    output logic [rob_pkg::COM_W-1:0][rob_pkg::LREG_W-1:0]   com_lrd,
    output logic [rob_pkg::COM_W-1:0][rob_pkg::PREG_W-1:0]   com_prd,
    output logic [rob_pkg::RET_W-1:0]                        retire_cnt
);

    logic ready;

    always_comb begin
        ready      = !trunc_valid;              // a redirect blocks all commits
        retire_cnt = '0;
        for (int i = 0; i < rob_pkg::COM_W; i++) begin
            raddr[i] = head + rob_pkg::IDX_W'(i);
            ready    = ready && (rob_pkg::CNT_W'(i) < rob_count)
                             && done[raddr[i]] && !faulted[raddr[i]];
            com_valid[i] = ready;               // stays low after the first gap
            com_opid[i]  = raddr[i];
            com_pc[i]    = dec_rvalue[i].pc;
            com_lrd[i]   = dec_rvalue[i].lrd;
            com_prd[i]   = ren_rvalue[i].prd;
            if (ready) begin
                retire_cnt = retire_cnt + rob_pkg::RET_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_redirect.sv
// rob_redirect: oldest misprediction, oldest trap value and redirect arbitration of the ROB
`timescale 1ns/100ps
`default_nettype none

module rob_redirect (
    input  logic                                           clk,
    input  logic                                           rst,
    input  rob_pkg::rob_idx_t                              head,
    input  logic [rob_pkg::CNT_W-1:0]                      rob_count,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                  done,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                  faulted,
    input  logic [rob_pkg::XLEN-1:0]                       head_pc,
    input  rob_pkg::rob_cause_t                            head_cause,
    input  logic [rob_pkg::EXE_W-1:0]                      exe_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::EXE_W-1:0]         exe_opid,
    input  rob_pkg::rob_cause_t [rob_pkg::EXE_W-1:0]       exe_cause,
    input  logic [rob_pkg::EXE_W-1:0][rob_pkg::XLEN-1:0]   exe_tval,
    input  logic [rob_pkg::EXE_W-1:0]                      exe_misp,
    input  logic [rob_pkg::EXE_W-1:0][rob_pkg::XLEN-1:0]   exe_npc,
    input  logic [rob_pkg::XLEN-1:0]                       tvec,
    output logic                                           redir_valid,
    output rob_pkg::rob_idx_t                              redir_opid,
    output logic [rob_pkg::XLEN-1:0]                       redir_npc,
    output logic                                           exception,
    output logic [rob_pkg::XLEN-1:0]                       epc,
    output rob_pkg::rob_cause_t                            cause,
    output logic [rob_pkg::XLEN-1:0]                       tval,
    output logic                                           trunc_valid,
    output rob_pkg::rob_idx_t                              trunc_opid
);

    logic                      mis_vld_n;
    logic                      mis_vld_q;
    rob_pkg::rob_idx_t         mis_id_n;
    rob_pkg::rob_idx_t         mis_id_q;
    logic [rob_pkg::XLEN-1:0]  mis_npc_n;
    logic [rob_pkg::XLEN-1:0]  mis_npc_q;
    logic                      flt_vld_n;
    logic                      flt_vld_q;
    rob_pkg::rob_idx_t         flt_id_n;
    rob_pkg::rob_idx_t         flt_id_q;
    logic [rob_pkg::XLEN-1:0]  tval_n;
    logic [rob_pkg::XLEN-1:0]  tval_q;

    // distance from the head, smaller is older
    function automatic rob_pkg::rob_idx_t age(input rob_pkg::rob_idx_t id);
        return id - head;
    endfunction

    assign exception = (rob_count != '0) && done[head] && faulted[head];
    assign epc       = head_pc;
    assign cause     = head_cause;
    assign tval      = tval_q;

    always_comb begin
        redir_valid = 1'b0;
        redir_opid  = mis_id_q;
        redir_npc   = mis_npc_q & ~rob_pkg::XLEN'(1);   // keep fetch aligned
        if (exception) begin
            redir_valid = 1'b1;
            redir_opid  = head;
            redir_npc   = tvec;
        end else if (mis_vld_q) begin
            redir_valid = 1'b1;
        end
    end

    assign trunc_valid = redir_valid;
    assign trunc_opid  = exception ? head - rob_pkg::IDX_W'(1) : mis_id_q;

    always_comb begin
        mis_vld_n = 1'b0;
        mis_id_n  = exe_opid[0];
        mis_npc_n = exe_npc[0];
        flt_vld_n = flt_vld_q;
        flt_id_n  = flt_id_q;
        tval_n    = tval_q;
        for (int i = 0; i < rob_pkg::EXE_W; i++) begin
            if (exe_valid[i] && exe_misp[i]
                    && (!mis_vld_n || age(exe_opid[i]) < age(mis_id_n))) begin
                mis_vld_n = 1'b1;
                mis_id_n  = exe_opid[i];
                mis_npc_n = exe_npc[i];
            end
            if (exe_valid[i] && exe_cause[i][rob_pkg::CAUSE_VLD]
                    && (!flt_vld_n || age(exe_opid[i]) < age(flt_id_n))) begin
                flt_vld_n = 1'b1;
                flt_id_n  = exe_opid[i];
                tval_n    = exe_tval[i];
            end
        end
        // anything younger than this cycle's redirect is flushed
        if (redir_valid && age(mis_id_n) > age(redir_opid)) begin
            mis_vld_n = 1'b0;
        end
        if (exception || (redir_valid && age(flt_id_n) > age(redir_opid))) begin
            flt_vld_n = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mis_vld_q <= 1'b0;
            flt_vld_q <= 1'b0;
        end else begin
            mis_vld_q <= mis_vld_n;
            flt_vld_q <= flt_vld_n;
        end
    end

    always_ff @(posedge clk) begin
        mis_id_q  <= mis_id_n;
        mis_npc_q <= mis_npc_n;
        flt_id_q  <= flt_id_n;
        tval_q    <= tval_n;
    end

    // a taken trap empties the buffer and leaves nothing pending
    a_exc_flush: assert property (@(posedge clk) disable iff (rst)
        exception |-> redir_valid ##1 (rob_count == '0 && !mis_vld_q && !flt_vld_q));

endmodule

`default_nettype wire

//--- hw/rob_top.sv
// rob_top: commit stage of the core built around the reorder buffer
`timescale 1ns/100ps
`default_nettype none

module rob_top (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [rob_pkg::DEC_W-1:0]                        dec_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::DEC_W-1:0]           dec_opid,
    input  logic [rob_pkg::DEC_W-1:0][rob_pkg::XLEN-1:0]     dec_pc,
    input  logic [rob_pkg::DEC_W-1:0][rob_pkg::LREG_W-1:0]   dec_lrd,
    input  logic [rob_pkg::REN_W-1:0]                        ren_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::REN_W-1:0]           ren_opid,
    input  logic [rob_pkg::REN_W-1:0][rob_pkg::PREG_W-1:0]   ren_prd,
    input  logic [rob_pkg::EXE_W-1:0]                        exe_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::EXE_W-1:0]           exe_opid,
    input  rob_pkg::rob_cause_t [rob_pkg::EXE_W-1:0]         exe_cause,
    input  logic [rob_pkg::EXE_W-1:0][rob_pkg::XLEN-1:0]     exe_tval,
    input  logic [rob_pkg::EXE_W-1:0]                        exe_misp,
    input  logic [rob_pkg::EXE_W-1:0][rob_pkg::XLEN-1:0]     exe_npc,
    input  logic [rob_pkg::XLEN-1:0]                         tvec,
    output logic [rob_pkg::COM_W-1:0]                        com_valid,
    output rob_pkg::rob_idx_t [rob_pkg::COM_W-1:0]           com_opid,
    output logic [rob_pkg::COM_W-1:0][rob_pkg::XLEN-1:0]     com_pc,
    output logic [rob_pkg::COM_W-1:0][rob_pkg::LREG_W-1:0]   com_lrd,
    output logic [rob_pkg::COM_W-1:0][rob_pkg::PREG_W-1:0]   com_prd,
    output logic                                             redir_valid,
    output rob_pkg::rob_idx_t                                redir_opid,
    output logic [rob_pkg::XLEN-1:0]                         redir_npc,
    output logic                                             exception,
    output logic [rob_pkg::XLEN-1:0]                         epc,
    output rob_pkg::rob_cause_t                              cause,
    output logic [rob_pkg::XLEN-1:0]                         tval,
    output logic [rob_pkg::CNT_W-1:0]                        rob_count
);

    rob_pkg::rob_dec_t [rob_pkg::DEC_W-1:0]  dec_wvalue;
    rob_pkg::rob_ren_t [rob_pkg::REN_W-1:0]  ren_wvalue;
    rob_pkg::rob_dec_t [rob_pkg::COM_W-1:0]  dec_rvalue;
    rob_pkg::rob_ren_t [rob_pkg::COM_W-1:0]  ren_rvalue;
    rob_pkg::rob_idx_t [rob_pkg::COM_W-1:0]  raddr;
    rob_pkg::rob_idx_t                       head;
    rob_pkg::rob_cause_t                     head_cause;
    logic [rob_pkg::ROB_DEPTH-1:0]           done;
    logic [rob_pkg::ROB_DEPTH-1:0]           faulted;
    logic [rob_pkg::RET_W-1:0]               retire_cnt;
    logic                                    trunc_valid;
    rob_pkg::rob_idx_t                       trunc_opid;

    always_comb begin
        for (int i = 0; i < rob_pkg::DEC_W; i++) begin
            dec_wvalue[i].pc  = dec_pc[i];
            dec_wvalue[i].lrd = dec_lrd[i];
        end
        for (int i = 0; i < rob_pkg::REN_W; i++) begin
            ren_wvalue[i].prd = ren_prd[i];
        end
    end

    rob_mwp_ram #(.payload_t(rob_pkg::rob_dec_t), .DEPTH(rob_pkg::ROB_DEPTH),
                  .RPORTS(rob_pkg::COM_W), .WPORTS(rob_pkg::DEC_W)) u_dec_ram (
        .clk(clk), .rst(rst), .waddr(dec_opid), .wvalue(dec_wvalue), .wena(dec_valid),
        .raddr(raddr), .rvalue(dec_rvalue));

    rob_mwp_ram #(.payload_t(rob_pkg::rob_ren_t), .DEPTH(rob_pkg::ROB_DEPTH),
                  .RPORTS(rob_pkg::COM_W), .WPORTS(rob_pkg::REN_W)) u_ren_ram (
        .clk(clk), .rst(rst), .waddr(ren_opid), .wvalue(ren_wvalue), .wena(ren_valid),
        .raddr(raddr), .rvalue(ren_rvalue));

    // cause only matters at the head
    rob_mwp_ram #(.payload_t(rob_pkg::rob_cause_t), .DEPTH(rob_pkg::ROB_DEPTH),
                  .RPORTS(1), .WPORTS(rob_pkg::EXE_W)) u_cause_ram (
        .clk(clk), .rst(rst), .waddr(exe_opid), .wvalue(exe_cause), .wena(exe_valid),
        .raddr(head), .rvalue(head_cause));

    rob_status u_status (
        .clk(clk), .rst(rst), .dec_valid(dec_valid), .dec_opid(dec_opid),
        .exe_valid(exe_valid), .exe_opid(exe_opid), .exe_cause(exe_cause),
        .retire_cnt(retire_cnt), .trunc_valid(trunc_valid), .trunc_opid(trunc_opid),
        .head(head), .rob_count(rob_count), .done(done), .faulted(faulted));

    rob_commit_select u_commit (
        .head(head), .rob_count(rob_count), .done(done), .faulted(faulted),
        .dec_rvalue(dec_rvalue), .ren_rvalue(ren_rvalue), .trunc_valid(trunc_valid),
        .raddr(raddr), .com_valid(com_valid), .com_opid(com_opid), .com_pc(com_pc),
        .com_lrd(com_lrd), .com_prd(com_prd), .retire_cnt(retire_cnt));

    rob_redirect u_redirect (
        .clk(clk), .rst(rst), .head(head), .rob_count(rob_count), .done(done),
        .faulted(faulted), .head_pc(dec_rvalue[0].pc), .head_cause(head_cause),
        .exe_valid(exe_valid), .exe_opid(exe_opid), .exe_cause(exe_cause),
        .exe_tval(exe_tval), .exe_misp(exe_misp), .exe_npc(exe_npc), .tvec(tvec),
        .redir_valid(redir_valid), .redir_opid(redir_opid), .redir_npc(redir_npc),
        .exception(exception), .epc(epc), .cause(cause), .tval(tval),
        .trunc_valid(trunc_valid), .trunc_opid(trunc_opid));

endmodule

`default_nettype wire

//--- dv/rob_clk_gen.sv
// rob_clk_gen: free running testbench clock and power-on reset
`timescale 1ns/100ps
`default_nettype none

module rob_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;                          // released just after an edge
    end

endmodule

`default_nettype wire

//--- dv/rob_tb.sv
// rob_tb: random batches of operations through the ROB with commit and redirect checks
`timescale 1ns/100ps
`default_nettype none

module rob_tb;

    localparam int N_BATCH   = 40;
    localparam int N_OPS     = N_BATCH * rob_pkg::ROB_DEPTH;
    localparam int KIND_EXC  = 2;
    localparam int KIND_MISP = 3;
    localparam int DEPTH     = rob_pkg::ROB_DEPTH;

    logic clk;
    logic rst;

    logic [rob_pkg::DEC_W-1:0]                      dec_valid;
    rob_pkg::rob_idx_t [rob_pkg::DEC_W-1:0]         dec_opid;
    logic [rob_pkg::DEC_W-1:0][rob_pkg::XLEN-1:0]   dec_pc;
    logic [rob_pkg::DEC_W-1:0][rob_pkg::LREG_W-1:0] dec_lrd;
    logic [rob_pkg::REN_W-1:0]                      ren_valid;
    rob_pkg::rob_idx_t [rob_pkg::REN_W-1:0]         ren_opid;
    logic [rob_pkg::REN_W-1:0][rob_pkg::PREG_W-1:0] ren_prd;
    logic [rob_pkg::EXE_W-1:0]                      exe_valid;
    rob_pkg::rob_idx_t [rob_pkg::EXE_W-1:0]         exe_opid;
    rob_pkg::rob_cause_t [rob_pkg::EXE_W-1:0]       exe_cause;
    logic [rob_pkg::EXE_W-1:0][rob_pkg::XLEN-1:0]   exe_tval;
    logic [rob_pkg::EXE_W-1:0]                      exe_misp;
    logic [rob_pkg::EXE_W-1:0][rob_pkg::XLEN-1:0]   exe_npc;
    logic [rob_pkg::XLEN-1:0]                       tvec;
    logic [rob_pkg::COM_W-1:0]                      com_valid;
    rob_pkg::rob_idx_t [rob_pkg::COM_W-1:0]         com_opid;
    logic [rob_pkg::COM_W-1:0][rob_pkg::XLEN-1:0]   com_pc;
    logic [rob_pkg::COM_W-1:0][rob_pkg::LREG_W-1:0] com_lrd;
    logic [rob_pkg::COM_W-1:0][rob_pkg::PREG_W-1:0] com_prd;
    logic                                           redir_valid;
    rob_pkg::rob_idx_t                              redir_opid;
    logic [rob_pkg::XLEN-1:0]                       redir_npc;
    logic                                           exception;
    logic [rob_pkg::XLEN-1:0]                       epc;
    rob_pkg::rob_cause_t                            cause;
    logic [rob_pkg::XLEN-1:0]                       tval;
    logic [rob_pkg::CNT_W-1:0]                      rob_count;

    // reference model of the outstanding operations
    logic [rob_pkg::XLEN-1:0]   pc_m  [DEPTH];
    logic [rob_pkg::LREG_W-1:0] lrd_m [DEPTH];
    logic [rob_pkg::PREG_W-1:0] prd_m [DEPTH];
    logic [DEPTH-1:0]           exec_m;
    rob_pkg::rob_idx_t          exp_id [rob_pkg::COM_W];
    rob_pkg::rob_idx_t          base = '0;
    rob_pkg::rob_idx_t          bad_id = '0;
    rob_pkg::rob_idx_t          next_id = '0;
    rob_pkg::rob_cause_t        cause_m;
    logic [rob_pkg::XLEN-1:0]   tval_m;
    logic [rob_pkg::XLEN-1:0]   mis_npc_m;
    int   kind = 0;
    int   pos = 0;
    int   lim = 0;                              // commits allowed in this batch
    int   tot_com;
    int   base_com = 0;
    int   bcommit;
    int   exc_cnt;
    int   exc_base = 0;
    logic mis_pend;
    logic exp_exc;
    logic batch_end = 1'b0;
    logic rst_q = 1'b0;
    logic [31:0] lcg_state = 32'd74;

    rob_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    rob_top UUT (.*);

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]) % n;
    endfunction

    function automatic logic [63:0] rand64();
        return {16'(rand_below(65536)), 16'(rand_below(65536)),
                16'(rand_below(65536)), 16'(rand_below(65536))};
    endfunction

    task automatic fail_run(input string msg);
        $display("Result: FAILED");
        $display("%s", msg);
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] expv,
                                   input logic [255:0] actv);
        fail_run($sformatf("Mismatch %s: expected %0h actual %0h", name, expv, actv));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_valids();
        dec_valid = '0;
        ren_valid = '0;
        exe_valid = '0;
        exe_misp  = '0;
    endtask

    always_comb begin
        bcommit = tot_com - base_com;
        for (int i = 0; i < rob_pkg::COM_W; i++) begin
            exp_id[i] = base + rob_pkg::IDX_W'(bcommit + i);
        end
        exp_exc = (kind == KIND_EXC) && exec_m[bad_id] && (bcommit == pos)
                  && (exc_cnt == exc_base);     // head is the faulting entry
    end

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            tot_com  <= 0;
            exc_cnt  <= 0;
            mis_pend <= 1'b0;
            exec_m   <= '0;
        end else begin
            tot_com  <= tot_com + $countones(com_valid);
            exc_cnt  <= exc_cnt + int'(exp_exc);
            mis_pend <= |(exe_valid & exe_misp);
            for (int j = 0; j < rob_pkg::DEC_W; j++) begin
                if (dec_valid[j]) exec_m[dec_opid[j]] <= 1'b0;
            end
            for (int j = 0; j < rob_pkg::EXE_W; j++) begin
                if (exe_valid[j]) exec_m[exe_opid[j]] <= 1'b1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) rst_q |->
        (com_valid == '0 && !redir_valid && !exception && rob_count == '0))
        else fail_run("outputs not idle during or right after reset");

    for (genvar i = 0; i < rob_pkg::COM_W; i++) begin : g_com
        a_exec: assert property (@(posedge clk) disable iff (rst)
            com_valid[i] |-> exec_m[exp_id[i]])
            else fail_run("entry committed before its execution finished");
        a_lim: assert property (@(posedge clk) disable iff (rst)
            com_valid[i] |-> (bcommit + i < lim))
            else fail_run("flushed or faulting entry committed");
        a_opid: assert property (@(posedge clk) disable iff (rst)
            com_valid[i] |-> com_opid[i] == exp_id[i])
            else report_mismatch("commit_opid", $sampled(exp_id[i]), $sampled(com_opid[i]));
        a_data: assert property (@(posedge clk) disable iff (rst) com_valid[i] |->
            {com_pc[i], com_lrd[i], com_prd[i]}
                == {pc_m[exp_id[i]], lrd_m[exp_id[i]], prd_m[exp_id[i]]})
            else report_mismatch("commit_pc_lrd_prd",
                $sampled({pc_m[exp_id[i]], lrd_m[exp_id[i]], prd_m[exp_id[i]]}),
                $sampled({com_pc[i], com_lrd[i], com_prd[i]}));
    end

    a_prefix: assert property (@(posedge clk) disable iff (rst)
        !com_valid[0] |-> !com_valid[1])
        else fail_run("commit slots are not a prefix");
    a_exc_rise: assert property (@(posedge clk) disable iff (rst) exp_exc |-> exception)
        else fail_run("faulting entry at the head raised no exception");
    a_exc_spur: assert property (@(posedge clk) disable iff (rst) exception |-> exp_exc)
        else fail_run("exception raised without a faulting head entry");
    a_exc_data: assert property (@(posedge clk) disable iff (rst) exp_exc |->
        redir_valid && {epc, cause, tval, redir_opid, redir_npc}
            == {pc_m[bad_id], cause_m, tval_m, bad_id, tvec})
        else report_mismatch("exception_epc_cause_tval_opid_npc",
            $sampled({pc_m[bad_id], cause_m, tval_m, bad_id, tvec}),
            $sampled({epc, cause, tval, redir_opid, redir_npc}));
    a_exc_empty: assert property (@(posedge clk) disable iff (rst) exp_exc |=> rob_count == '0)
        else report_mismatch("exception_count", 0, $sampled(rob_count));
    a_mis: assert property (@(posedge clk) disable iff (rst) (mis_pend && !exp_exc) |->
        redir_valid && {redir_opid, redir_npc} == {bad_id, mis_npc_m & ~64'h1})
        else report_mismatch("misp_opid_npc", $sampled({bad_id, mis_npc_m & ~64'h1}),
            $sampled({redir_opid, redir_npc}));
    a_redir_spur: assert property (@(posedge clk) disable iff (rst)
        redir_valid |-> (exp_exc || mis_pend))
        else fail_run("redirect raised with no exception or misprediction");
    a_batch: assert property (@(posedge clk) disable iff (rst) batch_end |-> bcommit == lim)
        else report_mismatch("batch_commits", $sampled(lim), $sampled(bcommit));

    task automatic run_batch();
        int k;
        int n;
        int kind_n;
        int pos_n;
        int idx;
        int j;
        int tmp;
        int order [DEPTH];
        k        = 1 + rand_below(DEPTH);
        kind     = 0;
        lim      = 0;                           // nothing may commit before execute
        base     = next_id;
        base_com = tot_com;
        for (n = 0; n < k; ) begin              // decode, one or two per cycle
            for (int s = 0; s < rob_pkg::DEC_W; s++) begin
                if (n < k && (s == 0 || rand_below(2) == 1)) begin
                    dec_valid[s] = 1'b1;
                    dec_opid[s]  = base + rob_pkg::IDX_W'(n);
                    dec_pc[s]    = rand64();
                    dec_lrd[s]   = rob_pkg::LREG_W'(rand_below(32));
                    pc_m[dec_opid[s]]  = dec_pc[s];
                    lrd_m[dec_opid[s]] = dec_lrd[s];
                    n++;
                end
            end
            tick();
            clear_valids();
        end
        for (n = 0; n < k; ) begin              // rename write-back
            for (int s = 0; s < rob_pkg::REN_W; s++) begin
                if (n < k) begin
                    ren_valid[s] = 1'b1;
                    ren_opid[s]  = base + rob_pkg::IDX_W'(n);
                    ren_prd[s]   = rob_pkg::PREG_W'(rand_below(128));
                    prd_m[ren_opid[s]] = ren_prd[s];
                    n++;
                end
            end
            tick();
            clear_valids();
        end
        kind_n = rand_below(4);
        pos_n  = rand_below(k);
        for (int i = 0; i < k; i++) order[i] = i;
        for (int i = k - 1; i > 0; i--) begin   // shuffle the execution order
            j = rand_below(i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < k; i++) begin       // special entry executes last
            if (order[i] == pos_n) begin
                order[i] = order[k-1];
                order[k-1] = pos_n;
            end
        end
        bad_id   = base + rob_pkg::IDX_W'(pos_n);
        kind     = kind_n;
        pos      = pos_n;
        exc_base = exc_cnt;
        lim      = (kind_n == KIND_EXC) ? pos_n : (kind_n == KIND_MISP) ? pos_n + 1 : k;
        for (idx = 0; idx < k; ) begin
            if (rand_below(4) == 0) tick();     // idle execute cycle
            for (int s = 0; s < rob_pkg::EXE_W; s++) begin
                if (idx < k && (s == 0 || rand_below(2) == 1)) begin
                    exe_valid[s] = 1'b1;
                    exe_opid[s]  = base + rob_pkg::IDX_W'(order[idx]);
                    exe_cause[s] = '0;
                    exe_tval[s]  = rand64();
                    exe_npc[s]   = rand64();
                    if (order[idx] == pos_n && kind_n == KIND_EXC) begin
                        exe_cause[s] = 8'h80 | rob_pkg::CAUSE_W'(rand_below(16));
                        cause_m = exe_cause[s];
                        tval_m  = exe_tval[s];
                    end
                    if (order[idx] == pos_n && kind_n == KIND_MISP) begin
                        exe_misp[s] = 1'b1;
                        mis_npc_m   = exe_npc[s];
                    end
                    idx++;
                end
            end
            tick();
            clear_valids();
        end
        while (rob_count != '0) tick();
        tick();
        batch_end = 1'b1;
        tick();
        batch_end = 1'b0;
        next_id   = base + rob_pkg::IDX_W'(lim);
    endtask

    initial begin
        clear_valids();
        dec_opid  = '0;
        dec_pc    = '0;
        dec_lrd   = '0;
        ren_opid  = '0;
        ren_prd   = '0;
        exe_opid  = '0;
        exe_cause = '0;
        exe_tval  = '0;
        exe_npc   = '0;
        tvec      = rand64() & ~64'h3;
        @(negedge rst);
        repeat (N_BATCH) run_batch();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #((N_OPS * 20 + 100) * 100);
        fail_run("timeout: run did not finish in time");
    end

endmodule

`default_nettype wire

//--- project.f
hw/rob_pkg.sv
hw/rob_mwp_ram.sv
hw/rob_status.sv
hw/rob_commit_select.sv
hw/rob_redirect.sv
hw/rob_top.sv
dv/rob_clk_gen.sv
dv/rob_tb.sv

//--- Bender.yml
package:
  name: rob_commit

sources:
  - hw/rob_pkg.sv
  - hw/rob_mwp_ram.sv
  - hw/rob_status.sv
  - hw/rob_commit_select.sv
  - hw/rob_redirect.sv
  - hw/rob_top.sv
  - target: test
    files:
      - dv/rob_clk_gen.sv
      - dv/rob_tb.sv
